// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --timing
TOP       := tb_sli_pattern
FILELIST  := project.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation finished: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tb_sli_pattern.sv ====
`timescale 1ns/1ps

module tb_sli_pattern;

	localparam int H_ACTIVE = 10;
	localparam int H_TOTAL = 16;
	localparam int V_ACTIVE = 8;
	localparam int V_TOTAL = 12;
	// one stripe period over the visible rows, projector 2 at 16x
	localparam logic [31:0] INC_1 = 32'((64'd1 << 32) / 64'(V_ACTIVE));
	localparam logic [31:0] INC_2 = INC_1 * 32'd16;
	localparam logic [31:0] STEP_1 = 32'h2000_0000;	// 1/8 turn per frame
	localparam logic [31:0] STEP_2 = 32'h4000_0000;	// 1/4 turn per frame
	localparam int N_TAB = 14;
	// reset, 1024 loads plus the readback, then the table frames and alignment
	localparam int LIMIT = 10 + 1024 * 4 + 800 + (N_TAB + 3) * H_TOTAL * V_TOTAL;

	logic        CLK_50M;
	logic        rst_n;
	logic        sync_in_1, sync_in_2;
	logic        sync_out_1, sync_out_2, hsync, vsync, de;
	logic [7:0]  pixel_1, pixel_2;
	logic [11:0] s_axil_awaddr, s_axil_araddr;
	logic [31:0] s_axil_wdata, s_axil_rdata;
	logic [3:0]  s_axil_wstrb;
	logic [1:0]  s_axil_bresp, s_axil_rresp;
	logic        s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready;
	logic        s_axil_bvalid, s_axil_bready;
	logic        s_axil_arvalid, s_axil_arready, s_axil_rvalid, s_axil_rready;

	logic [7:0]  lut_model [0:1023];	// what the host wrote
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;

	sli_pattern_top #(
		.H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL)
	) u_sli_pattern_top (.*);

	initial begin
		CLK_50M = 1'b0;
		forever #10 CLK_50M = ~CLK_50M;
	end

	always @(posedge CLK_50M) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout: run still going after %0d clock cycles", cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	////////////////////
	// helpers

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// columns: sync_in_1, sync_in_2, frame index shown next, sync_out_1 gated on
	function automatic logic [5:0] table_row(input int i);
		case (i)
			0: return 6'b1_1_000_0;	// first ready frame end, armed only
			1: return 6'b1_1_001_1;	// second one, sync runs
			2: return 6'b1_1_010_1;
			3: return 6'b1_0_010_0;	// partner not ready, index holds
			4: return 6'b1_1_011_0;
			5: return 6'b1_1_100_1;
			6: return 6'b1_1_101_1;
			7: return 6'b1_1_110_1;
			8: return 6'b1_1_111_1;
			9: return 6'b1_1_000_1;	// index wraps
			10: return 6'b1_1_001_1;
			11: return 6'b0_1_000_0;	// restart pulse from the partner
			12: return 6'b1_1_001_1;
			13: return 6'b1_1_010_1;
			default: return 6'b0;
		endcase
	endfunction

	// entry at the top 10 bits of frame x step + row x increment
	function automatic logic [7:0] model_pixel(input logic [31:0] step, input logic [31:0] inc,
		input logic [2:0] frame, input int row);
		logic [31:0] ph;
		ph = step * 32'(frame) + inc * 32'(row);
		return lut_model[ph[31:22]];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic axi_write(input int idx, input logic [31:0] data, input logic [3:0] strb,
		input int hold);
		s_axil_awaddr = 12'(idx * 4);
		s_axil_wdata = data;
		s_axil_wstrb = strb;
		s_axil_awvalid = 1'b1;
		s_axil_wvalid = 1'b1;
		do @(negedge CLK_50M); while (s_axil_bvalid !== 1'b1);	// bvalid only follows a handshake
		check_value("s_axil_bresp", 32'(s_axil_bresp), 0);
		// request left up, refused while the response waits
		repeat (hold) begin
			@(negedge CLK_50M);
			check_value("s_axil_bvalid held", 32'(s_axil_bvalid), 1);
			check_value("s_axil_awready", 32'(s_axil_awready), 0);
			check_value("s_axil_wready", 32'(s_axil_wready), 0);
		end
		if (hold > 0) begin
			s_axil_bready = 1'b1;
			@(negedge CLK_50M);
			s_axil_bready = 1'b0;
			// response gone, so the same write is taken a second time
			check_value("s_axil_awready", 32'(s_axil_awready), 1);
			check_value("s_axil_wready", 32'(s_axil_wready), 1);
			@(negedge CLK_50M);
			check_value("s_axil_bvalid again", 32'(s_axil_bvalid), 1);
		end
		s_axil_awvalid = 1'b0;
		s_axil_wvalid = 1'b0;
		s_axil_bready = 1'b1;
		@(negedge CLK_50M);
		check_value("s_axil_bvalid", 32'(s_axil_bvalid), 0);
		s_axil_bready = 1'b0;
	endtask

	task automatic axi_read(input int idx, input int hold, output logic [31:0] data);
		check_value("s_axil_arready idle", 32'(s_axil_arready), 1);
		s_axil_araddr = 12'(idx * 4);
		s_axil_arvalid = 1'b1;
		do @(negedge CLK_50M); while (s_axil_rvalid !== 1'b1);
		s_axil_arvalid = 1'b0;
		data = s_axil_rdata;
		check_value("s_axil_rresp", 32'(s_axil_rresp), 0);
		repeat (hold) begin
			@(negedge CLK_50M);
			check_value("s_axil_rvalid held", 32'(s_axil_rvalid), 1);
			check_value("s_axil_rdata held", s_axil_rdata, data);
			check_value("s_axil_arready busy", 32'(s_axil_arready), 0);
		end
		s_axil_rready = 1'b1;
		@(negedge CLK_50M);
		check_value("s_axil_rvalid", 32'(s_axil_rvalid), 0);
		s_axil_rready = 1'b0;
	endtask

	////////////////////
	// test sequence

	initial begin
		logic [31:0] seed;
		logic [31:0] rd;
		logic [5:0]  ent;
		logic        gate;
		logic        pulse;
		logic        de_q;
		logic        vs_q;
		logic        done;
		int          base;
		int          row;
		int          col;
		int          idx;

		rst_n = 1'b0;
		sync_in_1 = 1'b1;
		sync_in_2 = 1'b0;	// partner not ready while the table loads
		s_axil_awaddr = '0;
		s_axil_awvalid = 1'b0;
		s_axil_wdata = '0;
		s_axil_wstrb = '0;
		s_axil_wvalid = 1'b0;
		s_axil_bready = 1'b0;
		s_axil_araddr = '0;
		s_axil_arvalid = 1'b0;
		s_axil_rready = 1'b0;

		base = errors;
		repeat (10) @(negedge CLK_50M);
		check_value("{de,hsync,vsync,sync_out_1,sync_out_2,bvalid,rvalid}",
			32'({de, hsync, vsync, sync_out_1, sync_out_2, s_axil_bvalid, s_axil_rvalid}), 0);
		check_value("pixel_1", 32'(pixel_1), 0);
		check_value("pixel_2", 32'(pixel_2), 0);
		rst_n = 1'b1;
		$display("reset values: %0d errors", errors - base);

		base = errors;
		seed = 32'ha6b06ff6;
		for (int i = 0; i < 1024; i++) begin
			seed = lcg_next(seed);
			lut_model[10'(i)] = seed[7:0];	// only the low byte lands in the table
			axi_write(i, seed, 4'hf, 0);
		end
		// rewrites under response back-pressure, the last one without byte 0
		for (int k = 0; k < 5; k++) begin
			seed = lcg_next(seed);
			idx = k * 211 + 7;
			if (k < 4)
				lut_model[10'(idx)] = seed[7:0];
			axi_write(idx, seed, (k < 4) ? 4'hf : 4'he, 4);
		end
		for (int k = 0; k < 20; k++) begin
			idx = (k < 5) ? k * 211 + 7 : k * 53;
			axi_read(idx, 3, rd);
			check_value($sformatf("s_axil_rdata[%0d]", idx), rd, {24'h0, lut_model[10'(idx)]});
		end
		$display("lut load and readback: %0d errors", errors - base);

		// line up with a vsync, each table row then covers one frame
		do @(negedge CLK_50M); while (vsync !== 1'b0);
		do @(negedge CLK_50M); while (vsync !== 1'b1);
		col = 0;	// first vsync clock is column 0 of the outputs
		gate = 1'b0;
		de_q = 1'b0;
		vs_q = 1'b1;
		for (int f = 0; f < N_TAB; f++) begin
			ent = table_row(f);
			sync_in_2 = ent[4];	// sampled at this frame's end
			pulse = !ent[5];
			row = 0;
			base = errors;
			done = 1'b0;
			while (!done) begin
				@(negedge CLK_50M);
				col = (col + 1) % H_TOTAL;
				sync_in_1 = 1'b1;
				if (pulse && !vsync) begin
					sync_in_1 = 1'b0;	// one clock, once vsync is over
					pulse = 1'b0;
				end
				if (de) begin
					check_value($sformatf("pixel_1 row %0d", row), 32'(pixel_1),
						32'(model_pixel(STEP_1, INC_1, ent[3:1], row)));
					check_value($sformatf("pixel_2 row %0d", row), 32'(pixel_2),
						32'(model_pixel(STEP_2, INC_2, ent[3:1], row)));
					check_value("sync_out_2", 32'(sync_out_2), 32'(ent[3:1] == 3'd1));
				end else begin
					check_value("pixel_1 blank", 32'(pixel_1), 0);
					check_value("pixel_2 blank", 32'(pixel_2), 0);
				end
				check_value("hsync", 32'(hsync), 32'(col == H_ACTIVE));	// column after active
				if (de_q && !de)
					row++;	// rows counted at the end of de
				if (vsync && !vs_q) begin
					gate = ent[0];
					done = 1'b1;
				end
				check_value("sync_out_1", 32'(sync_out_1), 32'(vsync && gate));
				de_q = de;
				vs_q = vsync;
			end
			$display("frame %0d index %0d gate %0d: %0d errors", f, ent[3:1], ent[0],
				errors - base);
		end

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== logic/frame_sequencer.sv ====
`timescale 1ns/1ps

module frame_sequencer (
	input  logic                        CLK_50M,
	input  logic                        rst_n,
	input  logic                        frame_end,
	input  logic                        vsync_raw,
	input  logic                        sync_in_1,
	input  logic                        sync_in_2,
	output logic [sli_pkg::FRAME_W-1:0] frame_idx,
	output logic                        sync_out_1,
	output logic                        sync_out_2
);

	localparam logic [sli_pkg::FRAME_W-1:0] LAST_FRAME =
		sli_pkg::FRAME_W'(sli_pkg::NUM_FRAMES - 1);

	sli_pkg::seq_state_e state;

	////////////////////
	// arming handshake

	// sync_in_1 low acts as a restart from the partner, checked every clock
	// sync_in_2 is the partner's ready flag, looked at once per frame
	always_ff @(posedge CLK_50M) begin
		if (!rst_n) begin
			state <= sli_pkg::SEQ_IDLE;
			frame_idx <= LAST_FRAME;
		end else if (!sync_in_1) begin
			state <= sli_pkg::SEQ_IDLE;
			frame_idx <= LAST_FRAME;	// next ready frame is frame 0
		end else if (frame_end) begin
			if (sync_in_2) begin
				if (frame_idx == LAST_FRAME)
					frame_idx <= '0;
				else
					frame_idx <= frame_idx + 1'b1;

				case (state)
					sli_pkg::SEQ_IDLE:  state <= sli_pkg::SEQ_ARMED;
					sli_pkg::SEQ_ARMED: state <= sli_pkg::SEQ_RUN;
					default:            state <= sli_pkg::SEQ_RUN;
				endcase
			end else begin
				state <= sli_pkg::SEQ_IDLE;	// partner dropped out, index holds
			end
		end
	end

	////////////////////
	// sync outputs

	// registered, so sync_out_1 lines up with the delayed vsync at the top
	always_ff @(posedge CLK_50M) begin
		if (!rst_n) begin
			sync_out_1 <= 1'b0;
			sync_out_2 <= 1'b0;
		end else begin
			sync_out_1 <= (state == sli_pkg::SEQ_RUN) && vsync_raw;
			sync_out_2 <= (frame_idx == sli_pkg::FRAME_W'(1));	// frame 1 marker
		end
	end

endmodule

// ==== logic/pattern_lut.sv ====
`timescale 1ns/1ps

module pattern_lut (
	input  logic                         CLK_50M,
	input  logic                         rst_n,
	// host write channels
	input  logic [sli_pkg::AXI_AW-1:0]   s_axil_awaddr,
	input  logic                         s_axil_awvalid,
	output logic                         s_axil_awready,
	input  logic [sli_pkg::AXI_DW-1:0]   s_axil_wdata,
	input  logic [sli_pkg::AXI_DW/8-1:0] s_axil_wstrb,
	input  logic                         s_axil_wvalid,
	output logic                         s_axil_wready,
	output logic [1:0]                   s_axil_bresp,
	output logic                         s_axil_bvalid,
	input  logic                         s_axil_bready,
	// host read channels
	input  logic [sli_pkg::AXI_AW-1:0]   s_axil_araddr,
	input  logic                         s_axil_arvalid,
	output logic                         s_axil_arready,
	output logic [sli_pkg::AXI_DW-1:0]   s_axil_rdata,
	output logic [1:0]                   s_axil_rresp,
	output logic                         s_axil_rvalid,
	input  logic                         s_axil_rready,
	// video side
	input  logic [sli_pkg::LUT_AW-1:0]   addr_1,
	input  logic [sli_pkg::LUT_AW-1:0]   addr_2,
	input  logic                         de_raw,
	output logic [sli_pkg::PIX_W-1:0]    pixel_1,
	output logic [sli_pkg::PIX_W-1:0]    pixel_2
);

	localparam int DEPTH = 2 ** sli_pkg::LUT_AW;

	logic [sli_pkg::PIX_W-1:0]  mem [0:DEPTH-1];
	logic [sli_pkg::LUT_AW-1:0] wr_idx;
	logic [sli_pkg::LUT_AW-1:0] rd_idx;
	logic                       wr_fire;
	logic                       rd_fire;

	// byte address to word index
	assign wr_idx = s_axil_awaddr[sli_pkg::LUT_AW+1:2];
	assign rd_idx = s_axil_araddr[sli_pkg::LUT_AW+1:2];

	////////////////////
	// write path

	// address and data taken together, nothing new while a response waits
	assign wr_fire = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
	assign s_axil_awready = wr_fire;
	assign s_axil_wready = wr_fire;
	assign s_axil_bresp = 2'b00;	// always OKAY

	always_ff @(posedge CLK_50M) begin
		if (wr_fire && s_axil_wstrb[0])
			mem[wr_idx] <= s_axil_wdata[sli_pkg::PIX_W-1:0];
	end

	always_ff @(posedge CLK_50M) begin
		if (!rst_n)
			s_axil_bvalid <= 1'b0;
		else if (wr_fire)
			s_axil_bvalid <= 1'b1;
		else if (s_axil_bready)
			s_axil_bvalid <= 1'b0;	// held until the host takes it
	end

	////////////////////
	// read path

	assign s_axil_arready = !s_axil_rvalid;
	assign rd_fire = s_axil_arvalid && s_axil_arready;
	assign s_axil_rresp = 2'b00;

	always_ff @(posedge CLK_50M) begin
		if (rd_fire)
			s_axil_rdata <= sli_pkg::AXI_DW'(mem[rd_idx]);	// zero-extended entry
	end

	always_ff @(posedge CLK_50M) begin
		if (!rst_n)
			s_axil_rvalid <= 1'b0;
		else if (rd_fire)
			s_axil_rvalid <= 1'b1;
		else if (s_axil_rready)
			s_axil_rvalid <= 1'b0;
	end

	////////////////////
	// video read ports

	// both projectors read every clock, blanking forced to black
	always_ff @(posedge CLK_50M) begin
		if (!rst_n) begin
			pixel_1 <= '0;
			pixel_2 <= '0;
		end else begin
			pixel_1 <= de_raw ? mem[addr_1] : '0;
			pixel_2 <= de_raw ? mem[addr_2] : '0;
		end
	end

endmodule

// ==== logic/phase_accumulator.sv ====
`timescale 1ns/1ps

module phase_accumulator #(
	parameter logic [sli_pkg::PHASE_W-1:0] PHASE_INC = 32'd7158278,
	parameter logic [sli_pkg::PHASE_W-1:0] PHASE_STEP = 32'h2000_0000
) (
	input  logic                        CLK_50M,
	input  logic                        rst_n,
	input  logic                        line_start,
	input  logic                        row_active,
	input  logic                        frame_end,
	input  logic [sli_pkg::FRAME_W-1:0] frame_idx,
	output logic [sli_pkg::PHASE_W-1:0] phase
);

	logic [sli_pkg::PHASE_W-1:0] phase_q;
	logic [sli_pkg::PHASE_W-1:0] phase_nxt;
	logic                        first_row;	// next line_start is row 0

	// the new row value is already visible in column 0,
	// so the first pixel of each row uses the right phase
	always_comb begin
		phase_nxt = phase_q;
		if (line_start) begin
			if (first_row)
				phase_nxt = sli_pkg::PHASE_W'(frame_idx) * PHASE_STEP;	// wraps mod 2^32
			else if (row_active)
				phase_nxt = phase_q + PHASE_INC;
		end
	end

	assign phase = phase_nxt;

	always_ff @(posedge CLK_50M) begin
		if (!rst_n) begin
			phase_q <= '0;
			first_row <= 1'b1;	// counters start at row 0
		end else begin
			phase_q <= phase_nxt;
			if (frame_end)
				first_row <= 1'b1;
			else if (line_start)
				first_row <= 1'b0;
		end
	end

endmodule

// ==== logic/sli_pattern_top.sv ====
`timescale 1ns/1ps

module sli_pattern_top #(
	parameter int H_ACTIVE = 800,	// 800x600 at 72 Hz fits a 50 MHz pixel rate
	parameter int H_TOTAL = 1040,
	parameter int V_ACTIVE = 600,
	parameter int V_TOTAL = 666,
	// projector 1, one stripe period over the visible rows
	parameter logic [sli_pkg::PHASE_W-1:0] INC_1 =
		sli_pkg::PHASE_W'((64'd1 << sli_pkg::PHASE_W) / V_ACTIVE),
	parameter logic [sli_pkg::PHASE_W-1:0] STEP_1 = 32'h2000_0000,	// 2^29, 1/8 turn
	// projector 2 runs 16x the stripe frequency
	parameter logic [sli_pkg::PHASE_W-1:0] INC_2 = INC_1 << 4,
	parameter logic [sli_pkg::PHASE_W-1:0] STEP_2 = 32'h4000_0000	// 2^30, 1/4 turn
) (
	input  logic                         CLK_50M,
	input  logic                         rst_n,
	input  logic                         sync_in_1,
	input  logic                         sync_in_2,
	output logic                         sync_out_1,
	output logic                         sync_out_2,
	output logic                         hsync,
	output logic                         vsync,
	output logic                         de,
	output logic [sli_pkg::PIX_W-1:0]    pixel_1,
	output logic [sli_pkg::PIX_W-1:0]    pixel_2,
	input  logic [sli_pkg::AXI_AW-1:0]   s_axil_awaddr,
	input  logic                         s_axil_awvalid,
	output logic                         s_axil_awready,
	input  logic [sli_pkg::AXI_DW-1:0]   s_axil_wdata,
	input  logic [sli_pkg::AXI_DW/8-1:0] s_axil_wstrb,
	input  logic                         s_axil_wvalid,
	output logic                         s_axil_wready,
	output logic [1:0]                   s_axil_bresp,
	output logic                         s_axil_bvalid,
	input  logic                         s_axil_bready,
	input  logic [sli_pkg::AXI_AW-1:0]   s_axil_araddr,
	input  logic                         s_axil_arvalid,
	output logic                         s_axil_arready,
	output logic [sli_pkg::AXI_DW-1:0]   s_axil_rdata,
	output logic [1:0]                   s_axil_rresp,
	output logic                         s_axil_rvalid,
	input  logic                         s_axil_rready
);

	logic                        line_start;
	logic                        frame_end;
	logic                        row_active;
	logic                        de_raw;
	logic                        hsync_raw;
	logic                        vsync_raw;
	logic [sli_pkg::FRAME_W-1:0] frame_idx;
	logic [sli_pkg::PHASE_W-1:0] phase_1;
	logic [sli_pkg::PHASE_W-1:0] phase_2;

	////////////////////
	// timing and sequencing

	video_timing #(
		.H_ACTIVE(H_ACTIVE),
		.H_TOTAL (H_TOTAL),
		.V_ACTIVE(V_ACTIVE),
		.V_TOTAL (V_TOTAL)
	) u_video_timing (
		.CLK_50M   (CLK_50M),
		.rst_n     (rst_n),
		.line_start(line_start),
		.frame_end (frame_end),
		.row_active(row_active),
		.de_raw    (de_raw),
		.hsync_raw (hsync_raw),
		.vsync_raw (vsync_raw)
	);

	frame_sequencer u_frame_sequencer (
		.CLK_50M   (CLK_50M),
		.rst_n     (rst_n),
		.frame_end (frame_end),
		.vsync_raw (vsync_raw),
		.sync_in_1 (sync_in_1),
		.sync_in_2 (sync_in_2),
		.frame_idx (frame_idx),
		.sync_out_1(sync_out_1),
		.sync_out_2(sync_out_2)
	);

	////////////////////
	// one accumulator per projector

	phase_accumulator #(.PHASE_INC(INC_1), .PHASE_STEP(STEP_1)) u_phase_1 (
		.CLK_50M   (CLK_50M),
		.rst_n     (rst_n),
		.line_start(line_start),
		.row_active(row_active),
		.frame_end (frame_end),
		.frame_idx (frame_idx),
		.phase     (phase_1)
	);

	phase_accumulator #(.PHASE_INC(INC_2), .PHASE_STEP(STEP_2)) u_phase_2 (
		.CLK_50M   (CLK_50M),
		.rst_n     (rst_n),
		.line_start(line_start),
		.row_active(row_active),
		.frame_end (frame_end),
		.frame_idx (frame_idx),
		.phase     (phase_2)
	);

	////////////////////
	// pattern table

	pattern_lut u_pattern_lut (
		.CLK_50M       (CLK_50M),
		.rst_n         (rst_n),
		.s_axil_awaddr (s_axil_awaddr),
		.s_axil_awvalid(s_axil_awvalid),
		.s_axil_awready(s_axil_awready),
		.s_axil_wdata  (s_axil_wdata),
		.s_axil_wstrb  (s_axil_wstrb),
		.s_axil_wvalid (s_axil_wvalid),
		.s_axil_wready (s_axil_wready),
		.s_axil_bresp  (s_axil_bresp),
		.s_axil_bvalid (s_axil_bvalid),
		.s_axil_bready (s_axil_bready),
		.s_axil_araddr (s_axil_araddr),
		.s_axil_arvalid(s_axil_arvalid),
		.s_axil_arready(s_axil_arready),
		.s_axil_rdata  (s_axil_rdata),
		.s_axil_rresp  (s_axil_rresp),
		.s_axil_rvalid (s_axil_rvalid),
		.s_axil_rready (s_axil_rready),
		.addr_1        (phase_1[sli_pkg::PHASE_W-1 -: sli_pkg::LUT_AW]),	// top 10 bits
		.addr_2        (phase_2[sli_pkg::PHASE_W-1 -: sli_pkg::LUT_AW]),
		.de_raw        (de_raw),
		.pixel_1       (pixel_1),
		.pixel_2       (pixel_2)
	);

	// syncs and de follow the registered pixels by one clock
	always_ff @(posedge CLK_50M) begin
		if (!rst_n) begin
			hsync <= 1'b0;
			vsync <= 1'b0;
			de <= 1'b0;
		end else begin
			hsync <= hsync_raw;
			vsync <= vsync_raw;
			de <= de_raw;
		end
	end

endmodule

// ==== logic/sli_pkg.sv ====
package sli_pkg;

	////////////////////
	// phase and pixel widths

	localparam int PHASE_W = 32;	// dds phase word
	localparam int LUT_AW = 10;	// lut index, top bits of the phase
	localparam int PIX_W = 8;	// one lut entry, one pixel

	////////////////////
	// pattern sequence

	localparam int FRAME_W = 3;	// frame index width
	localparam int NUM_FRAMES = 8;	// phase-shifted frames per sequence

	////////////////////
	// host bus

	// byte address, word index sits in bits 11..2
	localparam int AXI_AW = 12;
	localparam int AXI_DW = 32;

	////////////////////
	// sequencer states

	// idle: partner not ready or just reset
	// armed: one ready frame seen, sync still held back
	// run: sync forwarded to the partner
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_ARMED,
		SEQ_RUN
	} seq_state_e;

endpackage

// ==== logic/video_timing.sv ====
`timescale 1ns/1ps

module video_timing #(
	parameter int H_ACTIVE = 800,
	parameter int H_TOTAL = 1040,
	parameter int V_ACTIVE = 600,
	parameter int V_TOTAL = 666
) (
	input  logic CLK_50M,
	input  logic rst_n,
	output logic line_start,
	output logic frame_end,
	output logic row_active,
	output logic de_raw,
	output logic hsync_raw,
	output logic vsync_raw
);

	localparam int H_W = $clog2(H_TOTAL);
	localparam int V_W = $clog2(V_TOTAL);

	logic [H_W-1:0] col;
	logic [V_W-1:0] row;
	logic           col_last;
	logic           row_last;

	assign col_last = (col == H_W'(H_TOTAL - 1));
	assign row_last = (row == V_W'(V_TOTAL - 1));

	////////////////////
	// counters

	always_ff @(posedge CLK_50M) begin
		if (!rst_n) begin
			col <= '0;
			row <= '0;
		end else if (col_last) begin
			col <= '0;
			row <= row_last ? '0 : row + 1'b1;	// row steps at end of line
		end else begin
			col <= col + 1'b1;
		end
	end

	////////////////////
	// decoded events

	assign line_start = (col == '0);
	assign frame_end = col_last && row_last;	// one clock per frame
	assign row_active = (row < V_W'(V_ACTIVE));
	assign de_raw = (col < H_W'(H_ACTIVE)) && row_active;

	// sync pulses sit right after the visible area
	assign hsync_raw = (col == H_W'(H_ACTIVE));
	assign vsync_raw = (row == V_W'(V_ACTIVE));

endmodule

// ==== project.f ====
logic/sli_pkg.sv
logic/video_timing.sv
logic/frame_sequencer.sv
logic/phase_accumulator.sv
logic/pattern_lut.sv
logic/sli_pattern_top.sv
dv/tb_sli_pattern.sv
